/* hdl/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit import rv_core_pkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        run,
	input  wire logic [31:0] id_inst,
	input  wire id_exe_t     exe_stage,
	input  wire exe_mem_t    mem_stage,
	input  wire logic        branch_taken,
	output ctrl_t            id_ctrl,
	output word_t            id_imm,
	output logic             stall_if,
	output logic             stall_id,
	output logic             flush_id,
	output logic             flush_exe,
	output fwd_sel_e         fwd_a,
	output fwd_sel_e         fwd_b
);
	// Instruction fields
	opcode_e  opcode;
	reg_idx_t rs1, rs2, rd;
	logic     uses_rs1, uses_rs2, load_use;
	fwd_sel_e fwd_a_next, fwd_b_next;

	assign opcode = opcode_e'(id_inst[6:0]);
	assign rs1 = id_inst[19:15];
	assign rs2 = id_inst[24:20];
	assign rd = id_inst[11:7];
	assign uses_rs1 = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
	assign uses_rs2 = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};

	// Decode into control bits and immediate
	always_comb begin
		id_ctrl = '0;
		id_imm = '0;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				id_ctrl.valid = 1'b1;
				id_ctrl.reg_we = 1'b1;
				id_ctrl.use_imm = (opcode == OPC_OP_IMM);
				id_imm = {{20{id_inst[31]}}, id_inst[31:20]};
				case (id_inst[14:12])
					3'b010: id_ctrl.alu_op = ALU_SLT;
					3'b100: id_ctrl.alu_op = ALU_XOR;
					3'b110: id_ctrl.alu_op = ALU_OR;
					3'b111: id_ctrl.alu_op = ALU_AND;
					// SUB only exists in register form
					default: id_ctrl.alu_op = (opcode == OPC_OP && id_inst[30]) ? ALU_SUB : ALU_ADD;
				endcase
			end
			OPC_LUI: begin
				id_ctrl = '{alu_op: ALU_PASS_B, use_imm: 1'b1, reg_we: 1'b1, valid: 1'b1,
					default: 1'b0};
				id_imm = {id_inst[31:12], 12'b0};
			end
			OPC_LOAD: begin
				id_ctrl = '{alu_op: ALU_ADD, use_imm: 1'b1, reg_we: 1'b1, mem_re: 1'b1,
					valid: 1'b1, default: 1'b0};
				id_imm = {{20{id_inst[31]}}, id_inst[31:20]};
			end
			OPC_STORE: begin
				id_ctrl = '{alu_op: ALU_ADD, use_imm: 1'b1, mem_we: 1'b1, valid: 1'b1,
					default: 1'b0};
				id_imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
			end
			OPC_BRANCH: begin
				// funct3 bit 0 picks BNE over BEQ
				id_ctrl = '{alu_op: ALU_ADD, is_branch: 1'b1, branch_ne: id_inst[12],
					valid: 1'b1, default: 1'b0};
				id_imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
					id_inst[11:8], 1'b0};
			end
			OPC_JAL: begin
				id_ctrl = '{alu_op: ALU_ADD, is_jal: 1'b1, reg_we: 1'b1, valid: 1'b1,
					default: 1'b0};
				id_imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
					id_inst[30:21], 1'b0};
			end
			default: ;
		endcase
		// x0 writes are dropped here so nothing downstream sees them
		if (rd == '0)
			id_ctrl.reg_we = 1'b0;
	end

	// Load in execute feeding a source of decode
	assign load_use = exe_stage.ctrl.valid && exe_stage.ctrl.mem_re && exe_stage.rd != '0 &&
		((uses_rs1 && rs1 == exe_stage.rd) || (uses_rs2 && rs2 == exe_stage.rd));

	// Branch redirect and halt override the stall
	assign stall_id = load_use && run && !branch_taken;
	assign stall_if = stall_id;
	assign flush_id = branch_taken || !run;
	assign flush_exe = branch_taken || load_use || !run;

	// Source picked now for the cycle this instruction spends in execute
	function automatic fwd_sel_e pick_src(input reg_idx_t src, input logic used);
		fwd_sel_e sel;
		sel = FWD_RF;
		if (used && src != '0) begin
			// Instruction now in execute will sit in memory next cycle
			if (exe_stage.ctrl.valid && exe_stage.ctrl.reg_we && exe_stage.rd == src)
				sel = FWD_MEM;
			else if (mem_stage.ctrl.valid && mem_stage.ctrl.reg_we && mem_stage.rd == src)
				sel = FWD_WB;
		end
		return sel;
	endfunction

	// Also follows the execute and memory stage fields read inside pick_src
	always_comb begin
		fwd_a_next = pick_src(rs1, uses_rs1);
		fwd_b_next = pick_src(rs2, uses_rs2);
	end

	// Moves with the ID/EXE register and falls back to register reads on a bubble
	always_ff @(posedge clk) begin
		if (reset || flush_exe) begin
			fwd_a <= FWD_RF;
			fwd_b <= FWD_RF;
		end else begin
			fwd_a <= fwd_a_next;
			fwd_b <= fwd_b_next;
		end
	end

	// The instruction that redirects is never the load behind a stall
	a_no_stall_on_redirect: assert property (@(posedge clk) disable iff (reset)
		!(load_use && branch_taken));
endmodule

`default_nettype wire

/* hdl/datamem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_config.svh"

module datamem import rv_core_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  re,
	input  wire logic  we,
	input  wire word_t addr,
	input  wire word_t wdata,
	output word_t      rdata
);
	word_t mem [`RV_DMEM_WORDS];
	logic [DMEM_AW-1:0] index;

	// Word index, byte offset dropped
	assign index = addr[DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (we)
			mem[index] <= wdata;
	end

	// Combinational read in the memory stage
	assign rdata = mem[index];

	a_word_aligned: assert property (@(posedge clk) disable iff (reset)
		(re || we) |-> addr[1:0] == 2'b00);
endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_unit import rv_core_pkg::*; (
	input  wire id_exe_t  stage_in,
	input  wire fwd_sel_e fwd_a,
	input  wire fwd_sel_e fwd_b,
	input  wire word_t    mem_result,
	input  wire word_t    wb_result,
	output word_t         alu_result,
	output word_t         store_data,
	output logic          branch_taken,
	output pc_t           target
);
	word_t op_a, op_b, alu_b, alu_out;
	logic  equal;

	// Forwarding muxes
	always_comb begin
		case (fwd_a)
			FWD_MEM: op_a = mem_result;
			FWD_WB:  op_a = wb_result;
			default: op_a = stage_in.rs1_data;
		endcase
		case (fwd_b)
			FWD_MEM: op_b = mem_result;
			FWD_WB:  op_b = wb_result;
			default: op_b = stage_in.rs2_data;
		endcase
	end

	// Store data is the forwarded rs2, never the immediate
	assign store_data = op_b;
	assign alu_b = stage_in.ctrl.use_imm ? stage_in.imm : op_b;

	always_comb begin
		case (stage_in.ctrl.alu_op)
			ALU_SUB:    alu_out = op_a - alu_b;
			ALU_AND:    alu_out = op_a & alu_b;
			ALU_OR:     alu_out = op_a | alu_b;
			ALU_XOR:    alu_out = op_a ^ alu_b;
			ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(alu_b));
			// LUI
			ALU_PASS_B: alu_out = alu_b;
			default:    alu_out = op_a + alu_b;
		endcase
	end

	// Link address for JAL
	assign alu_result = stage_in.ctrl.is_jal ? word_t'(stage_in.pc + pc_t'(4)) : alu_out;

	// BEQ/BNE compare on forwarded registers
	assign equal = (op_a == op_b);
	assign branch_taken = stage_in.ctrl.valid &&
		(stage_in.ctrl.is_jal || (stage_in.ctrl.is_branch && (equal ^ stage_in.ctrl.branch_ne)));
	assign target = stage_in.pc + pc_t'(stage_in.imm);
endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_config.svh"

module fetch_unit import rv_core_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  run,
	input  wire logic  stall,
	input  wire logic  redirect,
	input  wire pc_t   target,
	input  wire logic  prog_valid,
	input  wire prog_t prog,
	output logic       prog_ready,
	output if_id_t     if_out
);
	logic [31:0] imem [`RV_IMEM_WORDS];
	pc_t         pc_q;

	// Program port only open while halted
	assign prog_ready = !run;

	always_ff @(posedge clk) begin
		if (prog_valid && prog_ready)
			imem[prog.addr] <= prog.inst;
	end

	// PC parked at zero while halted
	always_ff @(posedge clk) begin
		if (reset || !run)
			pc_q <= '0;
		else if (redirect)
			pc_q <= target;
		else if (!stall)
			pc_q <= pc_q + pc_t'(4);
	end

	// Word index from PC bits above the byte offset
	assign if_out = '{pc: pc_q, inst: imem[pc_q[IMEM_AW+1:2]]};

	// Instruction memory is frozen while running, so a held PC sees the same word
	a_no_load_while_run: assert property (@(posedge clk) disable iff (reset)
		run && $past(run) && pc_q == $past(pc_q) |-> if_out.inst == $past(if_out.inst));
endmodule

`default_nettype wire

/* hdl/pipe_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
	parameter type T = logic
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic stall,
	input  wire logic flush,
	input  wire T     d,
	output T          q
);
	// Zero contents are a bubble since ctrl.valid clears too
	always_ff @(posedge clk) begin
		if (reset || flush)
			q <= '0;
		else if (!stall)
			q <= d;
	end

	// Control must never ask for both
	a_no_stall_and_flush: assert property (@(posedge clk) disable iff (reset)
		!(stall && flush));
endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile import rv_core_pkg::*; (
	input  wire logic     clk,
	input  wire logic     reset,
	input  wire reg_idx_t rs1,
	input  wire reg_idx_t rs2,
	input  wire reg_idx_t rd,
	input  wire logic     we,
	input  wire word_t    wdata,
	output word_t         rs1_data,
	output word_t         rs2_data
);
	word_t regs [32];

	// x0 cleared by reset and never written after
	always_ff @(posedge clk) begin
		if (reset)
			regs[0] <= '0;
		else if (we && rd != '0)
			regs[rd] <= wdata;
	end

	// Same-cycle write shows through to decode, except for x0
	assign rs1_data = (we && rd != '0 && rd == rs1) ? wdata : regs[rs1];
	assign rs2_data = (we && rd != '0 && rd == rs2) ? wdata : regs[rs2];

	a_x0_zero: assert property (@(posedge clk) disable iff (reset)
		(rs1 == '0 -> rs1_data == '0) && (rs2 == '0 -> rs2_data == '0));
endmodule

`default_nettype wire

/* hdl/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data path width
`define RV_XLEN 32

// Byte PC width
`define RV_PC_W 12

// Instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 256

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

`endif

/* hdl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;
	`include "rv_core_config.svh"

	// Derived memory index widths
	localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
	localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_PC_W-1:0] pc_t;
	typedef logic [4:0]          reg_idx_t;
	typedef logic [IMEM_AW-1:0]  imem_addr_t;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
	} alu_op_e;

	// Operand source seen by execute
	typedef enum logic [1:0] {
		FWD_RF, FWD_MEM, FWD_WB
	} fwd_sel_e;

	// All zeros is a bubble
	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    reg_we;
		logic    mem_re;
		logic    mem_we;
		logic    is_branch;
		logic    branch_ne;
		logic    is_jal;
		logic    valid;
	} ctrl_t;

	typedef struct packed {
		pc_t         pc;
		logic [31:0] inst;
	} if_id_t;

	typedef struct packed {
		ctrl_t    ctrl;
		pc_t      pc;
		word_t    rs1_data;
		word_t    rs2_data;
		word_t    imm;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
	} id_exe_t;

	typedef struct packed {
		ctrl_t    ctrl;
		pc_t      pc;
		word_t    alu_result;
		word_t    store_data;
		reg_idx_t rd;
	} exe_mem_t;

	typedef struct packed {
		ctrl_t    ctrl;
		pc_t      pc;
		word_t    wb_data;
		reg_idx_t rd;
	} mem_wb_t;

	// One word on the program load port
	typedef struct packed {
		imem_addr_t  addr;
		logic [31:0] inst;
	} prog_t;

	typedef struct packed {
		pc_t      pc;
		reg_idx_t rd;
		logic     reg_we;
		word_t    data;
	} retire_t;
endpackage

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_top import rv_core_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  run,
	input  wire logic  prog_valid,
	input  wire prog_t prog,
	output logic       prog_ready,
	output logic       retire_valid,
	output retire_t    retire
);
	// IF stage
	if_id_t   if_out;
	// ID stage
	if_id_t   id_stage;
	ctrl_t    id_ctrl;
	word_t    id_imm, id_rs1_data, id_rs2_data;
	id_exe_t  id_exe_d;
	// EXE stage
	id_exe_t  exe_stage;
	word_t    exe_alu_result, exe_store_data;
	logic     branch_taken;
	pc_t      branch_target;
	exe_mem_t exe_mem_d;
	// MEM stage
	exe_mem_t mem_stage;
	word_t    mem_rdata;
	mem_wb_t  mem_wb_d;
	// WB stage
	mem_wb_t  wb_stage;
	// Hazard control
	logic     stall_if, stall_id, flush_id, flush_exe;
	fwd_sel_e fwd_a, fwd_b;

	fetch_unit u_fetch (
		.clk(clk), .reset(reset), .run(run),
		.stall(stall_if), .redirect(branch_taken), .target(branch_target),
		.prog_valid(prog_valid), .prog(prog), .prog_ready(prog_ready),
		.if_out(if_out)
	);

	pipe_reg #(.T(if_id_t)) u_if_id (
		.clk(clk), .reset(reset), .stall(stall_id), .flush(flush_id),
		.d(if_out), .q(id_stage)
	);

	control_unit u_ctrl (
		.clk(clk), .reset(reset), .run(run),
		.id_inst(id_stage.inst), .exe_stage(exe_stage), .mem_stage(mem_stage),
		.branch_taken(branch_taken),
		.id_ctrl(id_ctrl), .id_imm(id_imm),
		.stall_if(stall_if), .stall_id(stall_id),
		.flush_id(flush_id), .flush_exe(flush_exe),
		.fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	// Writes come from WB, reads from decode
	regfile u_rf (
		.clk(clk), .reset(reset),
		.rs1(id_stage.inst[19:15]), .rs2(id_stage.inst[24:20]),
		.rd(wb_stage.rd), .we(wb_stage.ctrl.valid && wb_stage.ctrl.reg_we),
		.wdata(wb_stage.wb_data),
		.rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
	);

	always_comb begin
		id_exe_d.ctrl = id_ctrl;
		id_exe_d.pc = id_stage.pc;
		id_exe_d.rs1_data = id_rs1_data;
		id_exe_d.rs2_data = id_rs2_data;
		id_exe_d.imm = id_imm;
		id_exe_d.rs1 = id_stage.inst[19:15];
		id_exe_d.rs2 = id_stage.inst[24:20];
		id_exe_d.rd = id_stage.inst[11:7];
	end

	// Never stalled, a load-use hazard inserts a bubble here
	pipe_reg #(.T(id_exe_t)) u_id_exe (
		.clk(clk), .reset(reset), .stall(1'b0), .flush(flush_exe),
		.d(id_exe_d), .q(exe_stage)
	);

	// MEM forward value is the MEM stage writeback value
	execute_unit u_exe (
		.stage_in(exe_stage), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.mem_result(mem_wb_d.wb_data), .wb_result(wb_stage.wb_data),
		.alu_result(exe_alu_result), .store_data(exe_store_data),
		.branch_taken(branch_taken), .target(branch_target)
	);

	assign exe_mem_d = '{ctrl: exe_stage.ctrl, pc: exe_stage.pc, alu_result: exe_alu_result,
		store_data: exe_store_data, rd: exe_stage.rd};

	// Halt drains the back half too
	pipe_reg #(.T(exe_mem_t)) u_exe_mem (
		.clk(clk), .reset(reset), .stall(1'b0), .flush(!run),
		.d(exe_mem_d), .q(mem_stage)
	);

	datamem u_dmem (
		.clk(clk), .reset(reset),
		.re(mem_stage.ctrl.valid && mem_stage.ctrl.mem_re),
		.we(mem_stage.ctrl.valid && mem_stage.ctrl.mem_we),
		.addr(mem_stage.alu_result), .wdata(mem_stage.store_data),
		.rdata(mem_rdata)
	);

	// Load data or ALU result
	assign mem_wb_d = '{ctrl: mem_stage.ctrl, pc: mem_stage.pc,
		wb_data: mem_stage.ctrl.mem_re ? mem_rdata : mem_stage.alu_result, rd: mem_stage.rd};

	pipe_reg #(.T(mem_wb_t)) u_mem_wb (
		.clk(clk), .reset(reset), .stall(1'b0), .flush(!run),
		.d(mem_wb_d), .q(wb_stage)
	);

	// One record per instruction leaving WB
	assign retire_valid = wb_stage.ctrl.valid;
	assign retire = '{pc: wb_stage.pc, rd: wb_stage.rd, reg_we: wb_stage.ctrl.reg_we,
		data: wb_stage.wb_data};
endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module tb_rv_core \
	--Mdir obj_dir \
	-o tb_rv_core_sim

./obj_dir/tb_rv_core_sim > sim.log 2>&1 || true
cat sim.log

# The run passes only if the pass line is in the log
grep -q "^Done: no errors$" sim.log

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);
	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Held for three rising edges, released just after
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
	end
endmodule

`default_nettype wire

/* tb/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core import rv_core_pkg::*;;
	localparam int K_ADD = 0;
	localparam int K_SUB = 1;
	localparam int K_AND = 2;
	localparam int K_OR  = 3;
	localparam int K_XOR = 4;
	localparam int K_SLT = 5;

	logic    clk, reset, run, prog_valid, prog_ready, retire_valid;
	prog_t   prog;
	retire_t retire;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	// Grows as each test starts
	int budget = 200;
	logic [31:0] lfsr_state = 32'h79c9_eba3;

	// Program under construction and its expected retirements
	logic [31:0] prog_q[$];
	logic [11:0] exp_pc[$];
	logic        exp_we[$];
	logic [4:0]  exp_rd[$];
	logic [31:0] exp_data[$];
	// Architectural model
	logic [31:0] model_rf [32];
	logic [31:0] model_dm [int];

	tb_clock_gen u_clk (.clk(clk), .reset(reset));

	rv_core_top u_dut (
		.clk(clk), .reset(reset), .run(run),
		.prog_valid(prog_valid), .prog(prog), .prog_ready(prog_ready),
		.retire_valid(retire_valid), .retire(retire)
	);

	// Fibonacci LFSR on taps 32 22 2 1 stepped once per returned bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// Reference ALU from the ISA definitions
	function automatic logic [31:0] alu_ref(input int kind, input logic [31:0] a, b);
		case (kind)
			K_SUB: return a - b;
			K_AND: return a & b;
			K_OR:  return a | b;
			K_XOR: return a ^ b;
			K_SLT: return {31'b0, $signed(a) < $signed(b)};
			default: return a + b;
		endcase
	endfunction

	// Appends one word with or without an expected retirement
	task automatic put(input logic [31:0] inst, input logic retires, input logic we,
			input logic [4:0] rd, input logic [31:0] data);
		prog_q.push_back(inst);
		if (retires) begin
			exp_pc.push_back(12'((prog_q.size() - 1) * 4));
			exp_we.push_back(we);
			exp_rd.push_back(rd);
			exp_data.push_back(data);
		end
		if (we && rd != 5'd0)
			model_rf[rd] = data;
	endtask

	task automatic alu_rr(input int kind, input logic [4:0] rd, rs1, rs2);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] res;
		f7 = (kind == K_SUB) ? 7'b0100000 : 7'b0;
		case (kind)
			K_AND: f3 = 3'b111;
			K_OR:  f3 = 3'b110;
			K_XOR: f3 = 3'b100;
			K_SLT: f3 = 3'b010;
			default: f3 = 3'b000;
		endcase
		res = alu_ref(kind, model_rf[rs1], model_rf[rs2]);
		put({f7, rs2, rs1, f3, rd, 7'h33}, 1'b1, rd != 5'd0, rd, res);
	endtask

	task automatic addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
		put({imm, rs1, 3'b000, rd, 7'h13}, 1'b1, rd != 5'd0, rd, model_rf[rs1] + sext12(imm));
	endtask

	task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
		put({imm, rd, 7'h37}, 1'b1, rd != 5'd0, rd, {imm, 12'b0});
	endtask

	task automatic sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
		model_dm[int'(model_rf[rs1] + sext12(imm))] = model_rf[rs2];
		put({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23}, 1'b1, 1'b0, 5'd0, '0);
	endtask

	task automatic lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
		logic [31:0] data;
		data = model_dm[int'(model_rf[rs1] + sext12(imm))];
		put({imm, rs1, 3'b010, rd, 7'h03}, 1'b1, rd != 5'd0, rd, data);
	endtask

	// BEQ when ne is low, BNE when high
	task automatic cond_branch(input logic ne, input logic [4:0] rs1, rs2,
			input logic [12:0] off);
		put({off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'h63},
			1'b1, 1'b0, 5'd0, '0);
	endtask

	// Link value is the own PC plus four
	task automatic jal(input logic [4:0] rd, input logic [20:0] off, input logic retires);
		put({off[20], off[10:1], off[11], off[19:12], rd, 7'h6f}, retires, rd != 5'd0, rd,
			32'(prog_q.size() * 4 + 4));
	endtask

	// Never retires
	task automatic skipped(input logic [4:0] rd);
		prog_q.push_back({12'h7ff, 5'd0, 3'b000, rd, 7'h13});
	endtask

	task automatic begin_program();
		prog_q.delete();
		exp_pc.delete();
		exp_we.delete();
		exp_rd.delete();
		exp_data.delete();
	endtask

	// One retirement against the next expected entry
	task automatic check_retire(input string name, input int idx);
		checks++;
		assert (retire.pc == exp_pc[idx] && retire.reg_we == exp_we[idx] &&
				(!exp_we[idx] || (retire.rd == exp_rd[idx] &&
				retire.data == exp_data[idx]))) else begin
			errors++;
			$display("FAIL %0t: %s retire %0d got pc %h we %b x%0d=%h, want pc %h we %b x%0d=%h",
				$time, name, idx, retire.pc, retire.reg_we, retire.rd, retire.data,
				exp_pc[idx], exp_we[idx], exp_rd[idx], exp_data[idx]);
		end
	endtask

	// Halt and load, then run and check retirements in order
	task automatic run_program(input string name);
		int idx;
		int waited;
		int limit;
		jal(5'd0, 21'd0, 1'b0);
		budget += prog_q.size() * 8;
		limit = prog_q.size() * 8;
		@(posedge clk);
		#1 run = 1'b0;
		repeat (3) @(posedge clk);
		assert (prog_ready === 1'b1) else begin
			errors++;
			$display("FAIL %0t: %s prog_ready low while halted", $time, name);
		end
		for (int i = 0; i < prog_q.size(); i++) begin
			#1;
			prog_valid = 1'b1;
			prog = '{addr: imem_addr_t'(i), inst: prog_q[i]};
			// Transfer on an edge with ready high
			do
				@(posedge clk);
			while (prog_ready !== 1'b1);
		end
		#1;
		prog_valid = 1'b0;
		run = 1'b1;
		@(negedge clk);
		assert (prog_ready === 1'b0) else begin
			errors++;
			$display("FAIL %0t: %s prog_ready high while running", $time, name);
		end
		idx = 0;
		waited = 0;
		while (idx < exp_pc.size()) begin
			@(negedge clk);
			waited++;
			if (waited > limit) begin
				errors++;
				$display("%s stopped retiring after %0d of %0d instructions",
					name, idx, exp_pc.size());
				break;
			end
			if (retire_valid === 1'b1) begin
				check_retire(name, idx);
				idx++;
			end
		end
	endtask

	// Dependent chain where every operand comes from one or two instructions back
	task automatic alu_forwarding();
		begin_program();
		addi(5'd1, 5'd0, 12'(rand_bits(12)));
		addi(5'd2, 5'd0, 12'(rand_bits(12)));
		alu_rr(K_ADD, 5'd3, 5'd1, 5'd2);
		alu_rr(K_SUB, 5'd4, 5'd3, 5'd1);
		alu_rr(K_AND, 5'd5, 5'd4, 5'd3);
		alu_rr(K_OR, 5'd6, 5'd5, 5'd2);
		alu_rr(K_XOR, 5'd7, 5'd6, 5'd4);
		alu_rr(K_SLT, 5'd8, 5'd7, 5'd1);
		alu_rr(K_SLT, 5'd9, 5'd1, 5'd7);
		addi(5'd10, 5'd9, 12'(rand_bits(12)));
		run_program("alu_forwarding");
	endtask

	// LW result used by the very next instruction
	task automatic load_use_stall();
		begin_program();
		lui(5'd11, 20'(rand_bits(20)));
		addi(5'd11, 5'd11, 12'(rand_bits(12)));
		addi(5'd12, 5'd0, 12'h040);
		sw(5'd11, 5'd12, 12'd4);
		lw(5'd13, 5'd12, 12'd4);
		alu_rr(K_ADD, 5'd14, 5'd13, 5'd1);
		run_program("load_use");
	endtask

	// Taken BEQ over two words, then a BNE that falls through
	task automatic branch_skip();
		begin_program();
		addi(5'd15, 5'd0, 12'd5);
		addi(5'd16, 5'd0, 12'd5);
		cond_branch(1'b0, 5'd15, 5'd16, 13'd12);
		skipped(5'd17);
		skipped(5'd18);
		cond_branch(1'b1, 5'd15, 5'd16, 13'd8);
		addi(5'd19, 5'd15, 12'd1);
		run_program("branches");
	endtask

	// JAL link, x0 writes and LUI
	task automatic jal_x0_lui();
		begin_program();
		jal(5'd20, 21'd8, 1'b1);
		skipped(5'd21);
		addi(5'd0, 5'd0, 12'd123);
		alu_rr(K_ADD, 5'd22, 5'd0, 5'd20);
		alu_rr(K_OR, 5'd24, 5'd0, 5'd0);
		lui(5'd23, 20'(rand_bits(20)));
		run_program("jal_x0_lui");
	endtask

	// Reload after a finished run must start again at address 0
	task automatic second_program();
		begin_program();
		addi(5'd25, 5'd0, 12'(rand_bits(12)));
		addi(5'd26, 5'd25, 12'(rand_bits(12)));
		alu_rr(K_XOR, 5'd27, 5'd26, 5'd25);
		run_program("reload");
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles > budget) begin
			$display("Timeout after %0d cycles, the run is stopped", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		run = 1'b0;
		prog_valid = 1'b0;
		prog = '0;
		for (int i = 0; i < 32; i++)
			model_rf[i] = '0;
		wait (reset === 1'b0);
		alu_forwarding();
		load_use_stall();
		branch_skip();
		jal_x0_lui();
		second_program();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end
endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/pipe_reg.sv
hdl/control_unit.sv
hdl/regfile.sv
hdl/fetch_unit.sv
hdl/execute_unit.sv
hdl/datamem.sv
hdl/rv_core_top.sv
tb/tb_clock_gen.sv
tb/tb_rv_core.sv
